//--- verilog/arb_types_pkg.sv
package arb_types_pkg;

    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int LEN_W     = 5;   // lengths 1 to 16
    localparam int CREDIT_W  = 5;
    localparam int NUM_PORTS = 4;

    // token bit positions, reads come first
    localparam int SEL_RD0 = 0;
    localparam int SEL_RD1 = 1;
    localparam int SEL_WR0 = 2;
    localparam int SEL_WR1 = 3;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [LEN_W-1:0]     len_t;
    typedef logic [NUM_PORTS-1:0] port_sel_t;  // one-hot
    typedef logic [CREDIT_W-1:0]  credit_t;

endpackage

//--- verilog/arb_ctrl_pkg.sv
package arb_ctrl_pkg;

    typedef enum logic [1:0] {
        E_IDLE,
        E_WRITE,
        E_READ
    } eng_state_t;

    typedef enum logic [1:0] {
        P_IDLE,
        P_FILL,
        P_WAIT,
        P_DRAIN
    } port_state_t;

endpackage

//--- verilog/arb_ifs.sv
`timescale 1ns/10ps

interface port_req_if
    import arb_types_pkg::*;
();
    logic  req;     // held until done
    addr_t addr;
    len_t  len;
    logic  grant;
    logic  strobe;  // one word this cycle
    data_t wdata;
    data_t rdata;
    logic  done;

    modport port_mp (output req, addr, len, wdata, input grant, strobe, rdata, done);
    modport arb_mp (input req, addr, len, wdata, output grant, strobe, rdata, done);
endinterface

interface mem_cmd_if
    import arb_types_pkg::*;
();
    logic  valid;   // held until done
    logic  write;
    addr_t addr;
    len_t  len;
    logic  strobe;
    data_t wdata;
    data_t rdata;
    logic  done;

    modport arb_mp (output valid, write, addr, len, wdata, input strobe, rdata, done);
    modport eng_mp (input valid, write, addr, len, wdata, output strobe, rdata, done);
endinterface

//--- verilog/wr_port_buf.sv
`timescale 1ns/10ps

module wr_port_buf
    import arb_types_pkg::*;
    import arb_ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 16   // power of two, at least max len
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_start,
    input  addr_t      i_addr,
    input  len_t       i_len,
    input  logic       i_valid,
    input  data_t      i_data,
    output logic       o_busy,
    port_req_if.port_mp port
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    data_t            fifo [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    port_state_t      state;
    addr_t            addr_q;
    len_t             len_q;
    len_t             in_cnt;
    logic             take;
    logic             push;

    assign take   = (state == P_IDLE) && i_start && (i_len != '0);
    assign push   = (state == P_FILL) && i_valid;  // extra words never reach here
    assign o_busy = (state != P_IDLE);

    assign port.req   = (state == P_WAIT) || (state == P_DRAIN);
    assign port.addr  = addr_q;
    assign port.len   = len_q;
    assign port.wdata = fifo[rd_ptr];  // head word

    always_ff @(posedge i_clk) begin
        if (push) fifo[wr_ptr] <= i_data;
        if (take) begin
            addr_q <= i_addr;
            len_q  <= i_len;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= P_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            in_cnt <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (port.strobe) rd_ptr <= rd_ptr + 1'b1;  // engine took head word
            case (state)
                P_IDLE: if (take) begin
                    in_cnt <= '0;
                    state  <= P_FILL;
                end
                P_FILL: if (push) begin
                    in_cnt <= in_cnt + 1'b1;
                    if (in_cnt + 1'b1 == len_q) state <= P_WAIT;  // whole burst buffered
                end
                P_WAIT: if (port.grant) state <= P_DRAIN;
                P_DRAIN: if (port.done) state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/rd_port_buf.sv
`timescale 1ns/10ps

module rd_port_buf
    import arb_types_pkg::*;
    import arb_ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_start,
    input  addr_t      i_addr,
    input  len_t       i_len,
    input  logic       i_credit,
    output logic       o_valid,
    output data_t      o_data,
    output logic       o_busy,
    port_req_if.port_mp port
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    data_t            fifo [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   level;
    credit_t          credits;
    port_state_t      state;
    addr_t            addr_q;
    len_t             len_q;
    len_t             out_cnt;
    logic             take;
    logic             pop;

    assign take    = (state == P_IDLE) && i_start && (i_len != '0);
    assign pop     = (credits != '0) && (level != '0);
    assign o_valid = pop;
    assign o_data  = fifo[rd_ptr];
    assign o_busy  = (state != P_IDLE);

    assign port.req   = (state == P_WAIT) || (state == P_FILL);
    assign port.addr  = addr_q;
    assign port.len   = len_q;
    assign port.wdata = '0;  // read port never supplies data

    always_ff @(posedge i_clk) begin
        if (port.strobe) fifo[wr_ptr] <= port.rdata;
        if (take) begin
            addr_q <= i_addr;
            len_q  <= i_len;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= P_IDLE;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
            credits <= '0;
            out_cnt <= '0;
        end else begin
            if (port.strobe) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({port.strobe, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            case ({i_credit, pop})
                2'b10:   if (credits != '1) credits <= credits + 1'b1;  // saturate
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            if (pop) out_cnt <= out_cnt + 1'b1;
            case (state)
                P_IDLE: if (take) begin
                    out_cnt <= '0;
                    state   <= P_WAIT;
                end
                P_WAIT:  if (port.grant) state <= P_FILL;
                P_FILL:  if (port.done) state <= P_DRAIN;
                P_DRAIN: if (pop && (out_cnt + 1'b1 == len_q)) state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter
    import arb_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    port_req_if.arb_mp rd0,
    port_req_if.arb_mp rd1,
    port_req_if.arb_mp wr0,
    port_req_if.arb_mp wr1,
    mem_cmd_if.arb_mp  mem
);
    port_sel_t token;
    port_sel_t next_token;
    port_sel_t req_vec;
    port_sel_t hold;
    logic      locked;

    assign req_vec    = {wr1.req, wr0.req, rd1.req, rd0.req};
    assign next_token = {token[NUM_PORTS-2:0], token[NUM_PORTS-1]};
    assign hold       = locked ? token : '0;  // only the holder sees the engine

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            token  <= port_sel_t'(1);  // rd0
            locked <= 1'b0;
        end else if (locked) begin
            if (mem.done) begin
                locked <= 1'b0;
                token  <= next_token;
            end
        end else if ((req_vec & token) != '0) begin
            locked <= 1'b1;
        end else begin
            token <= next_token;  // holder idle, keep rotating
        end
    end

    assign mem.valid = locked;
    assign mem.write = token[SEL_WR0] || token[SEL_WR1];

    always_comb begin
        mem.addr  = rd0.addr;
        mem.len   = rd0.len;
        mem.wdata = wr0.wdata;
        if (token[SEL_RD1]) begin
            mem.addr = rd1.addr;
            mem.len  = rd1.len;
        end else if (token[SEL_WR0]) begin
            mem.addr = wr0.addr;
            mem.len  = wr0.len;
        end else if (token[SEL_WR1]) begin
            mem.addr  = wr1.addr;
            mem.len   = wr1.len;
            mem.wdata = wr1.wdata;
        end
    end

    assign rd0.grant  = hold[SEL_RD0];
    assign rd0.strobe = hold[SEL_RD0] && mem.strobe;
    assign rd0.done   = hold[SEL_RD0] && mem.done;
    assign rd0.rdata  = mem.rdata;
    assign rd1.grant  = hold[SEL_RD1];
    assign rd1.strobe = hold[SEL_RD1] && mem.strobe;
    assign rd1.done   = hold[SEL_RD1] && mem.done;
    assign rd1.rdata  = mem.rdata;
    assign wr0.grant  = hold[SEL_WR0];
    assign wr0.strobe = hold[SEL_WR0] && mem.strobe;
    assign wr0.done   = hold[SEL_WR0] && mem.done;
    assign wr0.rdata  = mem.rdata;
    assign wr1.grant  = hold[SEL_WR1];
    assign wr1.strobe = hold[SEL_WR1] && mem.strobe;
    assign wr1.done   = hold[SEL_WR1] && mem.done;
    assign wr1.rdata  = mem.rdata;

endmodule

//--- verilog/burst_engine.sv
`timescale 1ns/10ps

module burst_engine
    import arb_types_pkg::*;
    import arb_ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    mem_cmd_if.eng_mp mem
);
    data_t      ram [2**ADDR_W];
    eng_state_t state;
    addr_t      ptr;      // wraps at top of memory
    len_t       cnt;      // words left to move or issue
    logic       wr_en;
    logic       rd_en;
    logic       rd_vld;
    logic       rd_last;
    data_t      rd_q;

    assign wr_en = (state == E_WRITE);
    assign rd_en = (state == E_READ) && (cnt != '0);

    assign mem.strobe = wr_en || rd_vld;
    assign mem.done   = (wr_en && (cnt == len_t'(1))) || (rd_vld && rd_last);
    assign mem.rdata  = rd_q;

    always_ff @(posedge i_clk) begin
        if (wr_en) ram[ptr] <= mem.wdata;
        if (rd_en) rd_q <= ram[ptr];  // one cycle read latency
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= E_IDLE;
            ptr     <= '0;
            cnt     <= '0;
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
        end else begin
            rd_vld  <= rd_en;
            rd_last <= rd_en && (cnt == len_t'(1));
            case (state)
                E_IDLE: if (mem.valid) begin
                    ptr   <= mem.addr;
                    cnt   <= mem.len;
                    state <= mem.write ? E_WRITE : E_READ;
                end
                E_WRITE, E_READ: begin
                    if (wr_en || rd_en) begin
                        ptr <= ptr + 1'b1;
                        cnt <= cnt - 1'b1;
                    end
                    if (mem.done) state <= E_IDLE;  // reads wait for the last word out
                end
                default: state <= E_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/sdram_port_arb.sv
`timescale 1ns/10ps

module sdram_port_arb
    import arb_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_wr0_start,
    input  addr_t i_wr0_addr,
    input  len_t  i_wr0_len,
    input  logic  i_wr0_valid,
    input  data_t i_wr0_data,
    output logic  o_wr0_busy,
    input  logic  i_wr1_start,
    input  addr_t i_wr1_addr,
    input  len_t  i_wr1_len,
    input  logic  i_wr1_valid,
    input  data_t i_wr1_data,
    output logic  o_wr1_busy,
    input  logic  i_rd0_start,
    input  addr_t i_rd0_addr,
    input  len_t  i_rd0_len,
    input  logic  i_rd0_credit,
    output logic  o_rd0_valid,
    output data_t o_rd0_data,
    output logic  o_rd0_busy,
    input  logic  i_rd1_start,
    input  addr_t i_rd1_addr,
    input  len_t  i_rd1_len,
    input  logic  i_rd1_credit,
    output logic  o_rd1_valid,
    output data_t o_rd1_data,
    output logic  o_rd1_busy
);
    port_req_if rd0_if ();
    port_req_if rd1_if ();
    port_req_if wr0_if ();
    port_req_if wr1_if ();
    mem_cmd_if  mem_if ();

    wr_port_buf #(.FIFO_DEPTH(FIFO_DEPTH)) u_wr0 (
        .i_clk, .i_reset, .i_start(i_wr0_start), .i_addr(i_wr0_addr), .i_len(i_wr0_len),
        .i_valid(i_wr0_valid), .i_data(i_wr0_data), .o_busy(o_wr0_busy), .port(wr0_if)
    );

    wr_port_buf #(.FIFO_DEPTH(FIFO_DEPTH)) u_wr1 (
        .i_clk, .i_reset, .i_start(i_wr1_start), .i_addr(i_wr1_addr), .i_len(i_wr1_len),
        .i_valid(i_wr1_valid), .i_data(i_wr1_data), .o_busy(o_wr1_busy), .port(wr1_if)
    );

    rd_port_buf #(.FIFO_DEPTH(FIFO_DEPTH)) u_rd0 (
        .i_clk, .i_reset, .i_start(i_rd0_start), .i_addr(i_rd0_addr), .i_len(i_rd0_len),
        .i_credit(i_rd0_credit), .o_valid(o_rd0_valid), .o_data(o_rd0_data),
        .o_busy(o_rd0_busy), .port(rd0_if)
    );

    rd_port_buf #(.FIFO_DEPTH(FIFO_DEPTH)) u_rd1 (
        .i_clk, .i_reset, .i_start(i_rd1_start), .i_addr(i_rd1_addr), .i_len(i_rd1_len),
        .i_credit(i_rd1_credit), .o_valid(o_rd1_valid), .o_data(o_rd1_data),
        .o_busy(o_rd1_busy), .port(rd1_if)
    );

    rr_arbiter u_arb (
        .i_clk, .i_reset,
        .rd0(rd0_if), .rd1(rd1_if), .wr0(wr0_if), .wr1(wr1_if), .mem(mem_if)
    );

    burst_engine u_eng (
        .i_clk, .i_reset, .mem(mem_if)
    );

endmodule

//--- tests/tb_sva.sv
`timescale 1ns/10ps

module tb_sva (
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_rd0_credit,
    input logic       i_rd1_credit,
    input logic       i_rd0_valid,
    input logic       i_rd1_valid,
    input logic [3:0] i_busy        // wr1 wr0 rd1 rd0
);
    int owed0;  // credits returned minus words delivered
    int owed1;

    always @(posedge i_clk) begin
        if (i_reset) begin
            owed0 <= 0;
            owed1 <= 0;
        end else begin
            owed0 <= owed0 + int'(i_rd0_credit) - int'(i_rd0_valid);
            owed1 <= owed1 + int'(i_rd1_credit) - int'(i_rd1_valid);
        end
    end

    rd0_needs_credit: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rd0_valid |-> (owed0 > 0))
        else $error("read port 0 delivered a word with zero credits");

    rd1_needs_credit: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rd1_valid |-> (owed1 > 0))
        else $error("read port 1 delivered a word with zero credits");

    // first reset edge clears the port FSMs
    idle_in_reset: assert property (@(posedge i_clk)
        (i_reset && $past(i_reset)) |-> (i_busy == '0))
        else $error("a busy flag is high while reset is held");

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/10ps

module tb_checker
    import arb_types_pkg::*;
(
    input logic       i_clk,
    input logic       i_reset,
    input logic [1:0] i_rd_valid,
    input data_t      i_rd0_data,
    input data_t      i_rd1_data,
    input logic [3:0] i_busy        // wr1 wr0 rd1 rd0
);
    data_t exp_q0 [$];
    data_t exp_q1 [$];
    int    rx_cnt [2];
    string name = "none";
    string port_names [4] = '{"rd0", "rd1", "wr0", "wr1"};
    int    test_err = 0;
    int    err_cnt = 0;
    int    run_cnt = 0;
    int    pass_cnt = 0;

    task automatic note_error(string msg);
        $display("%s", msg);
        test_err++;
        err_cnt++;
    endtask

    task automatic begin_test(string n);
        name     = n;
        test_err = 0;
        exp_q0.delete();
        exp_q1.delete();
    endtask

    task automatic expect_word(int p, data_t w);
        if (p == 0) exp_q0.push_back(w);
        else exp_q1.push_back(w);
    endtask

    task automatic clear_count(int p);
        rx_cnt[p] = 0;
    endtask

    task automatic take_word(int p, data_t act);
        data_t exp;
        rx_cnt[p]++;
        if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
            note_error($sformatf("%s: rd%0d delivered a word nobody asked for", name, p));
        end else begin
            if (p == 0) exp = exp_q0.pop_front();
            else exp = exp_q1.pop_front();
            if (act !== exp) begin
                note_error($sformatf("MISMATCH %s rd%0d word %0d: expected %h actual %h",
                                     name, p, rx_cnt[p], exp, act));
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (i_rd_valid[0]) take_word(0, i_rd0_data);
            if (i_rd_valid[1]) take_word(1, i_rd1_data);
        end
    end

    task automatic check_count(int p, int k);
        if (rx_cnt[p] != k) begin
            note_error($sformatf("MISMATCH %s rd%0d word count: expected %0d actual %0d",
                                 name, p, k, rx_cnt[p]));
        end
    endtask

    task automatic check_busy(int idx, logic exp);
        if (i_busy[idx] !== exp) begin
            note_error($sformatf("MISMATCH %s %s busy: expected %b actual %b",
                                 name, port_names[idx], exp, i_busy[idx]));
        end
    endtask

    task automatic check_idle();
        if ({i_busy, i_rd_valid} !== 6'b0) begin
            note_error($sformatf("MISMATCH %s busy and valid: expected %b actual %b",
                                 name, 6'b0, {i_busy, i_rd_valid}));
        end
    endtask

    task automatic end_test();
        if (exp_q0.size() + exp_q1.size() != 0) begin
            note_error($sformatf("%s: %0d expected read words never arrived",
                                 name, exp_q0.size() + exp_q1.size()));
        end
        run_cnt++;
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_err);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 run_cnt, pass_cnt, run_cnt - pass_cnt, err_cnt);
    endtask

endmodule

//--- tests/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import arb_types_pkg::*;
();
    localparam int QUIET_CYCLES = 40;  // back-pressure window

    logic        clk;
    logic        reset;
    logic [1:0]  wr_start;
    logic [1:0]  wr_valid;
    logic [1:0]  wr_busy;
    addr_t       wr_addr [2];
    len_t        wr_len [2];
    data_t       wr_data [2];
    logic [1:0]  rd_start;
    logic [1:0]  rd_credit;
    logic [1:0]  rd_valid;
    logic [1:0]  rd_busy;
    addr_t       rd_addr [2];
    len_t        rd_len [2];
    data_t       rd_data [2];
    logic [1:0]  feeding;              // write data still being driven
    logic [15:0] lfsr;
    int          cycles;
    int          limit;

    string op_name [$];
    string op_kind [$];
    int    op_port [$];
    addr_t op_addr [$];
    len_t  op_len [$];
    int    op_cnt [$];
    int    op_first [$];
    data_t words [$];

    sdram_port_arb #(.FIFO_DEPTH(16)) dut_i (
        .i_clk(clk), .i_reset(reset),
        .i_wr0_start(wr_start[0]), .i_wr0_addr(wr_addr[0]), .i_wr0_len(wr_len[0]),
        .i_wr0_valid(wr_valid[0]), .i_wr0_data(wr_data[0]), .o_wr0_busy(wr_busy[0]),
        .i_wr1_start(wr_start[1]), .i_wr1_addr(wr_addr[1]), .i_wr1_len(wr_len[1]),
        .i_wr1_valid(wr_valid[1]), .i_wr1_data(wr_data[1]), .o_wr1_busy(wr_busy[1]),
        .i_rd0_start(rd_start[0]), .i_rd0_addr(rd_addr[0]), .i_rd0_len(rd_len[0]),
        .i_rd0_credit(rd_credit[0]), .o_rd0_valid(rd_valid[0]), .o_rd0_data(rd_data[0]),
        .o_rd0_busy(rd_busy[0]),
        .i_rd1_start(rd_start[1]), .i_rd1_addr(rd_addr[1]), .i_rd1_len(rd_len[1]),
        .i_rd1_credit(rd_credit[1]), .o_rd1_valid(rd_valid[1]), .o_rd1_data(rd_data[1]),
        .o_rd1_busy(rd_busy[1])
    );

    tb_checker chk (
        .i_clk(clk), .i_reset(reset), .i_rd_valid(rd_valid),
        .i_rd0_data(rd_data[0]), .i_rd1_data(rd_data[1]), .i_busy({wr_busy, rd_busy})
    );

    bind sdram_port_arb tb_sva u_sva (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rd0_credit(i_rd0_credit), .i_rd1_credit(i_rd1_credit),
        .i_rd0_valid(o_rd0_valid), .i_rd1_valid(o_rd1_valid),
        .i_busy({o_wr1_busy, o_wr0_busy, o_rd1_busy, o_rd0_busy})
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16 14 13 11
    endfunction

    task automatic random_gap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic load_stim();
        int    fd;
        int    code;
        int    port;
        int    addr;
        int    len;
        int    cnt;
        int    w;
        string tok;
        string kind;
        string line;
        fd = $fopen("tests/arb_stim.txt", "r");
        if (fd == 0) begin
            chk.note_error("stimulus file tests/arb_stim.txt could not be opened");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == "#") begin
                    code = $fgets(line, fd);  // rest of a comment line
                end else begin
                    code = $fscanf(fd, "%s %d %h %d %d", kind, port, addr, len, cnt);
                    if (code != 5) begin
                        chk.note_error($sformatf("stimulus record %s is incomplete", tok));
                    end
                    op_name.push_back(tok);
                    op_kind.push_back(kind);
                    op_port.push_back(port);
                    op_addr.push_back(addr_t'(addr));
                    op_len.push_back(len_t'(len));
                    op_cnt.push_back(cnt);
                    op_first.push_back(words.size());
                    repeat ((kind == "r") ? len : cnt) begin
                        code = $fscanf(fd, "%h", w);
                        if (code != 1) begin
                            chk.note_error($sformatf("stimulus record %s is missing a word",
                                                     tok));
                        end
                        words.push_back(data_t'(w));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_burst(int p, addr_t a, len_t l, int n, int first);
        feeding[p] = 1'b1;
        step();
        wr_start[p] = 1'b1;
        wr_addr[p]  = a;
        wr_len[p]   = l;
        step();
        wr_start[p] = 1'b0;
        for (int k = 0; k < n; k++) begin
            wr_valid[p] = 1'b1;
            wr_data[p]  = words[first + k];
            step();
        end
        wr_valid[p] = 1'b0;
        feeding[p]  = 1'b0;
    endtask

    task automatic give_credits(int p, int n);
        int gap;
        repeat (n) begin
            rd_credit[p] = 1'b1;
            step();
            rd_credit[p] = 1'b0;
            random_gap(gap);
            repeat (gap) step();
        end
    endtask

    task automatic read_burst(int p, addr_t a, len_t l, int k, int first);
        wait (wr_busy == 2'b00 && feeding == 2'b00);  // reads see finished writes
        for (int j = 0; j < int'(l); j++) begin
            chk.expect_word(p, words[first + j]);
        end
        chk.clear_count(p);
        step();
        rd_start[p] = 1'b1;
        rd_addr[p]  = a;
        rd_len[p]   = l;
        step();
        rd_start[p] = 1'b0;
        give_credits(p, k);
        if (k < int'(l)) begin
            repeat (QUIET_CYCLES) step();
            chk.check_count(p, k);
            chk.check_busy(p, 1'b1);
            give_credits(p, int'(l) - k);
        end
        wait (rd_busy[p] == 1'b0);
    endtask

    task automatic run_op(int i);
        int p;
        p = op_port[i];
        if (op_kind[i] == "r") begin
            read_burst(p, op_addr[i], op_len[i], op_cnt[i], op_first[i]);
        end else if (op_kind[i] == "a") begin
            feeding[p] = 1'b1;
            fork
                write_burst(p, op_addr[i], op_len[i], op_cnt[i], op_first[i]);
            join_none
        end else begin
            if (op_kind[i] == "x") begin
                wait (feeding[p] == 1'b0);
                chk.check_busy(2 + p, 1'b1);  // second start must land while busy
            end
            write_burst(p, op_addr[i], op_len[i], op_cnt[i], op_first[i]);
            wait (wr_busy[p] == 1'b0);
        end
    endtask

    initial begin
        reset     = 1'b1;
        wr_start  = '0;
        wr_valid  = '0;
        rd_start  = '0;
        rd_credit = '0;
        feeding   = '0;
        foreach (wr_addr[j]) begin
            wr_addr[j] = '0;
            wr_len[j]  = '0;
            wr_data[j] = '0;
            rd_addr[j] = '0;
            rd_len[j]  = '0;
        end
        lfsr   = 16'd75;
        cycles = 0;
        limit  = 1000000;
        load_stim();
        limit = 200 + 40 * words.size();
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;
        chk.begin_test("reset");
        step();
        chk.check_idle();
        chk.end_test();
        for (int i = 0; i < op_name.size(); i++) begin
            if (i == 0 || op_name[i] != op_name[i - 1]) begin
                chk.begin_test(op_name[i]);
            end
            run_op(i);
            if (i == op_name.size() - 1 || op_name[i + 1] != op_name[i]) begin
                wait (wr_busy == 2'b00 && rd_busy == 2'b00 && feeding == 2'b00);
                chk.end_test();
            end
        end
        chk.report();
        if (chk.err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tests/arb_stim.txt
# columns are test name, kind, port, addr (hex), len, count, then words (hex)
# kind w writes and waits, a writes in background, x starts while busy, r reads with count credits
wr_rd  w 0 10 4 5 1111 2222 3333 4444 5555
wr_rd  r 0 10 4 4 1111 2222 3333 4444
conc   a 0 20 3 3 a001 a002 a003
conc   w 1 40 3 3 b001 b002 b003
conc   r 1 20 3 3 a001 a002 a003
conc   r 0 40 3 3 b001 b002 b003
credit w 0 60 6 6 c001 c002 c003 c004 c005 c006
credit r 1 60 6 2 c001 c002 c003 c004 c005 c006
credit r 0 60 4 0 c001 c002 c003 c004
wrap   w 1 fd 5 5 d0fd d0fe d0ff d000 d001
wrap   r 0 fe 2 2 d0fe d0ff
wrap   r 1 00 2 1 d000 d001
wrap   r 0 fd 5 5 d0fd d0fe d0ff d000 d001
busy   a 0 80 3 3 e001 e002 e003
busy   x 0 80 2 2 f001 f002
busy   r 1 80 3 3 e001 e002 e003

//--- tb.f
verilog/arb_types_pkg.sv
verilog/arb_ctrl_pkg.sv
verilog/arb_ifs.sv
verilog/wr_port_buf.sv
verilog/rd_port_buf.sv
verilog/rr_arbiter.sv
verilog/burst_engine.sv
verilog/sdram_port_arb.sv
tests/tb_sva.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Makefile
TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
